/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_control_unit
FILELIST = vlog.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/cu_ref_model.svh */
`ifndef CU_REF_MODEL_SVH
`define CU_REF_MODEL_SVH

cu_ctrl_pkg::cpu_cycle_t m_cycle;		// Cycle the DUT sequencer shows after the clock
cu_ctrl_pkg::ctrl_word_t m_ctrl;		// Expected registered control word
logic [15:0] m_psw;
logic m_fault;
logic m_active;							// CEX block open
logic m_result;							// CEX condition outcome
logic [2:0] m_tcnt;						// True group instructions left
logic [2:0] m_fcnt;						// False group instructions left
logic m_start;							// Model just entered FETCH of a new instruction

function automatic logic cond_holds(input logic [3:0] code, input logic [15:0] p);
	logic c;
	logic z;
	logic n;
	logic v;
	c = p[cu_isa_pkg::PSW_C];
	z = p[cu_isa_pkg::PSW_Z];
	n = p[cu_isa_pkg::PSW_N];
	v = p[cu_isa_pkg::PSW_V];
	case (code)
		cu_isa_pkg::CC_EQ: return z;
		cu_isa_pkg::CC_NE: return !z;
		cu_isa_pkg::CC_CS: return c;
		cu_isa_pkg::CC_CC: return !c;
		cu_isa_pkg::CC_MI: return n;
		cu_isa_pkg::CC_PL: return !n;
		cu_isa_pkg::CC_VS: return v;
		cu_isa_pkg::CC_VC: return !v;
		cu_isa_pkg::CC_HI: return c && !z;
		cu_isa_pkg::CC_LS: return !c || z;
		cu_isa_pkg::CC_GE: return n == v;
		cu_isa_pkg::CC_LT: return n != v;
		cu_isa_pkg::CC_GT: return !z && (n == v);
		cu_isa_pkg::CC_LE: return z || (n != v);
		cu_isa_pkg::CC_TR: return 1'b1;
		default: return 1'b0;				// FL
	endcase
endfunction

// Condition code that the current instruction tests
function automatic logic [3:0] cond_select(input cu_isa_pkg::instr_fields_t fl);
	if (fl.op == cu_isa_pkg::OP_CEX)
		return fl.c;
	else if (fl.op >= 7'd1 && fl.op <= 7'd5)
		return 4'(fl.op - 7'd1);			// EQ, NE, CS, CC, MI
	else if (fl.op == 7'd6 || fl.op == 7'd7)
		return 4'(fl.op + 7'd4);			// GE, LT
	else
		return cu_isa_pkg::CC_TR;			// BRA
endfunction

// Taken branch, also the BL jump
function automatic cu_ctrl_pkg::ctrl_word_t pc_target_word();
	cu_ctrl_pkg::ctrl_word_t w;
	w = '0;
	w.alu_en = 1'b1;						// ADD is op 0
	w.alu_rnum_dst = cu_ctrl_pkg::REG_PC;
	w.s_bus_sel = 1'b1;
	w.sxt_en = 1'b1;
	w.sxt_sel = 1'b1;
	w.sxt_bit = 4'd10;						// Branch offset sign bit
	w.dbus_wr = 1'b1;
	w.dbus_src = cu_ctrl_pkg::BUS_ALU;
	w.dbus_rnum_dst = cu_ctrl_pkg::REG_PC;
	return w;
endfunction

function automatic cu_ctrl_pkg::ctrl_word_t exec1_word(input cu_isa_pkg::instr_fields_t fl,
	input logic ct);
	cu_ctrl_pkg::ctrl_word_t w;
	w = '0;
	if ((fl.op >= 7'd9 && fl.op <= 7'd20) || fl.op == 7'd23 || fl.op == 7'd24)
	begin
		w.alu_en = 1'b1;
		if (fl.op <= 7'd20)
			w.alu_op = 6'(2 * (fl.op - 9) + fl.wb);		// ADD to BIS
		else
			w.alu_op = 6'(2 * (fl.op - 11) + fl.wb);	// SRA, RRC
		w.alu_rnum_dst = 5'(fl.dst);
		w.alu_rnum_src = 5'(fl.srccon + 8 * fl.rc);		// Constants sit above the registers
		w.psw_update = 1'b1;
		w.dbus_wr = 1'b1;
		w.dbus_wb = fl.wb;
		w.dbus_src = cu_ctrl_pkg::BUS_ALU;
		w.dbus_rnum_dst = 5'(fl.dst);
	end
	else if (fl.op == cu_isa_pkg::OP_MOV || fl.op == cu_isa_pkg::OP_SWAP)
	begin
		w.dbus_wr = 1'b1;
		w.dbus_src = cu_ctrl_pkg::BUS_REG;
		w.dbus_rnum_src = 5'(fl.srccon);
		w.dbus_wb = (fl.op == cu_isa_pkg::OP_MOV) && fl.wb;
		w.dbus_rnum_dst = (fl.op == cu_isa_pkg::OP_MOV) ? 5'(fl.dst) : cu_ctrl_pkg::REG_TEMP;
	end
	else if (fl.op == cu_isa_pkg::OP_BL)
	begin
		w = pc_target_word();					// Add prepared, PC copied to LR
		w.dbus_src = cu_ctrl_pkg::BUS_REG;
		w.dbus_rnum_src = cu_ctrl_pkg::REG_PC;
		w.dbus_rnum_dst = cu_ctrl_pkg::REG_LR;
	end
	else if (fl.op == cu_isa_pkg::OP_SWPB || (fl.op >= 7'd34 && fl.op <= 7'd37))
	begin
		w.bm_en = 1'b1;
		w.bm_op = (fl.op == cu_isa_pkg::OP_SWPB) ? 3'd4 : 3'(fl.op - 7'd34);
		w.unit_rnum = 5'(fl.dst);
		w.dbus_wr = 1'b1;
		w.dbus_src = cu_ctrl_pkg::BUS_UNIT;
		w.dbus_rnum_dst = 5'(fl.dst);
	end
	else if (fl.op == cu_isa_pkg::OP_SXT)
	begin
		w.sxt_en = 1'b1;
		w.sxt_bit = 4'd7;
		w.unit_rnum = 5'(fl.dst);
		w.dbus_wr = 1'b1;
		w.dbus_src = cu_ctrl_pkg::BUS_UNIT;
		w.dbus_rnum_dst = 5'(fl.dst);
	end
	else if (fl.op >= 7'd1 && fl.op <= 7'd8 && ct)
		w = pc_target_word();
	return w;								// SETCC, CLRCC, SETPRI, CEX stay idle
endfunction

function automatic cu_ctrl_pkg::ctrl_word_t expected_word(input cu_ctrl_pkg::cpu_cycle_t cyc,
	input cu_isa_pkg::instr_fields_t fl, input logic runs, input logic ct);
	cu_ctrl_pkg::ctrl_word_t w;
	w = '0;
	case (cyc)
		cu_ctrl_pkg::CYC_FETCH:
		begin
			w.mar_from_reg = 1'b1;
			w.addr_rnum_src = cu_ctrl_pkg::REG_PC;
			w.mem_rd = 1'b1;
		end
		cu_ctrl_pkg::CYC_PCINC:
		begin
			w.alu_en = 1'b1;
			w.alu_rnum_dst = cu_ctrl_pkg::REG_PC;
			w.alu_rnum_src = cu_ctrl_pkg::REG_CONST2;
			w.dbus_wr = 1'b1;
			w.dbus_src = cu_ctrl_pkg::BUS_ALU;
			w.dbus_rnum_dst = cu_ctrl_pkg::REG_PC;
		end
		cu_ctrl_pkg::CYC_IR:
		begin
			w.dbus_wr = 1'b1;
			w.dbus_src = cu_ctrl_pkg::BUS_IR;
		end
		cu_ctrl_pkg::CYC_DECODE: w.id_en = runs;
		cu_ctrl_pkg::CYC_EXEC1: w = exec1_word(fl, ct);
		default:
		begin
			if (fl.op == cu_isa_pkg::OP_BL)
				w = pc_target_word();			// Jump after the link
			else if (fl.op == cu_isa_pkg::OP_SWAP)
			begin
				w.dbus_wr = 1'b1;
				w.dbus_src = cu_ctrl_pkg::BUS_REG;
				w.dbus_rnum_src = cu_ctrl_pkg::REG_TEMP;
				w.dbus_rnum_dst = 5'(fl.dst);
			end
		end
	endcase
	return w;
endfunction

function automatic logic ends_here(input cu_ctrl_pkg::cpu_cycle_t cyc, input logic [6:0] op,
	input logic runs);
	case (cyc)
		cu_ctrl_pkg::CYC_DECODE: return !runs;	// Skipped instruction, 4 cycles
		cu_ctrl_pkg::CYC_EXEC1: return op != cu_isa_pkg::OP_SWAP && op != cu_isa_pkg::OP_BL;
		cu_ctrl_pkg::CYC_EXEC2: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

task automatic reset_model();
	m_cycle = cu_ctrl_pkg::CYC_FETCH;
	m_ctrl = '0;
	m_psw = cu_isa_pkg::PSW_RESET;
	m_fault = 1'b0;
	m_active = 1'b0;
	m_result = 1'b0;
	m_tcnt = 3'd0;
	m_fcnt = 3'd0;
	m_start = 1'b1;
endtask

// One clock of the control unit, from the inputs seen before the edge
task automatic advance_model(input cu_isa_pkg::instr_fields_t fl, input logic halted,
	input logic [15:0] pin, input logic pwr);
	logic ct;
	logic runs;
	logic last;
	logic in_exec1;
	logic lower;
	logic [15:0] p;
	ct = cond_holds(cond_select(fl), m_psw);
	runs = !m_active || ((m_tcnt != 3'd0) ? m_result : !m_result);	// True group first
	last = ends_here(m_cycle, fl.op, runs);
	in_exec1 = !halted && (m_cycle == cu_ctrl_pkg::CYC_EXEC1);
	lower = (fl.pr < m_psw[cu_isa_pkg::PSW_PRI_LO +: 3]);
	p = pwr ? pin : m_psw;
	if (in_exec1 && fl.op == cu_isa_pkg::OP_SETCC)
		p[4:0] = m_psw[4:0] | fl.pswb;		// Instruction beats a datapath load
	else if (in_exec1 && fl.op == cu_isa_pkg::OP_CLRCC)
		p[4:0] = m_psw[4:0] & ~fl.pswb;
	if (in_exec1 && fl.op == cu_isa_pkg::OP_SETPRI && lower)
		p[cu_isa_pkg::PSW_PRI_LO +: 3] = fl.pr;
	p[cu_isa_pkg::PSW_SLP] = halted;
	m_fault = in_exec1 && fl.op == cu_isa_pkg::OP_SETPRI && !lower;
	if (m_cycle == cu_ctrl_pkg::CYC_EXEC1 && fl.op == cu_isa_pkg::OP_CEX)
	begin
		m_active = (fl.t != 3'd0) || (fl.f != 3'd0);
		m_result = ct;
		m_tcnt = fl.t;
		m_fcnt = fl.f;
	end
	else if (m_cycle == cu_ctrl_pkg::CYC_DECODE && m_active)
	begin
		if (m_tcnt != 3'd0)
			m_tcnt = m_tcnt - 3'd1;
		else
			m_fcnt = m_fcnt - 3'd1;
		m_active = (m_tcnt != 3'd0) || (m_fcnt != 3'd0);
	end
	if (halted)
		m_ctrl = '0;						// Idle at a breakpoint
	else
		m_ctrl = expected_word(m_cycle, fl, runs, ct);
	if (!halted)
		m_cycle = last ? cu_ctrl_pkg::CYC_FETCH : m_cycle + 3'd1;
	m_start = !halted && last;
	m_psw = p;
endtask

`endif

/* verification/tb_control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit;

	localparam int NUM_INSTR = 400;
	localparam int MAX_CYC = 6;						// BL and SWAP
	localparam int TIMEOUT_CYCLES = NUM_INSTR * MAX_CYC + 100;
	localparam logic [15:0] NO_BRK = 16'hFFFF;		// Odd address that the even pc never reaches

	logic clock = 1'b0;
	logic cpucycle_rst;
	cu_isa_pkg::instr_fields_t fields;
	logic [15:0] pc;
	logic [15:0] brkpnt;
	logic [15:0] psw_in;
	logic psw_wr;
	cu_ctrl_pkg::ctrl_word_t ctrl;
	logic [15:0] psw_out;
	logic pri_fault;

	integer seed;
	int instr_cnt = 0;								// Instructions started
	int halt_left = 0;								// Clocks left in a breakpoint window
	int cyc_cnt = 0;

	`include "cu_ref_model.svh"

	control_unit i_dut (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .fields(fields), .pc(pc),
		.brkpnt(brkpnt), .psw_in(psw_in), .psw_wr(psw_wr), .ctrl(ctrl),
		.psw_out(psw_out), .pri_fault(pri_fault)
	);

	always #2 clock = ~clock;

	always @(posedge clock)
	begin
		cyc_cnt = cyc_cnt + 1;
		if (cyc_cnt > TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still going after %0d clock cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic report_error(input string what);
		$display("ERR %0t: %s", $time, what);
		$display("TEST FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_ctrl(input cu_ctrl_pkg::ctrl_word_t got,
		input cu_ctrl_pkg::ctrl_word_t exp);
		if (got !== exp)
			report_error($sformatf("ctrl %h, expected %h, op %0d", got, exp, fields.op));
	endtask

	task automatic check_psw(input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp)
			report_error($sformatf("psw_out %h, expected %h", got, exp));
	endtask

	task automatic check_fault(input logic got, input logic exp);
		if (got !== exp)
			report_error($sformatf("pri_fault %b, expected %b", got, exp));
	endtask

	function automatic cu_isa_pkg::instr_fields_t random_fields();
		cu_isa_pkg::instr_fields_t r;
		int k;
		k = {$random(seed)} % 38;
		if (k == 28 || k == 32 || k == 33)
			k = 31;									// Unused codes become extra CEX
		r.op = 7'(k);
		{r.dst, r.srccon, r.wb, r.rc, r.c, r.t, r.f, r.pr, r.pswb} = 26'($random(seed));
		return r;
	endfunction

	task automatic drive_inputs();
		logic [15:0] pc_nxt;
		psw_wr <= ({$random(seed)} % 8) == 0;		// Occasional datapath flag load
		psw_in <= 16'($random(seed));
		if (halt_left != 0)
		begin
			halt_left = halt_left - 1;
			if (halt_left == 0)
				brkpnt <= NO_BRK;					// Leave the breakpoint
		end
		else if (m_start && instr_cnt < NUM_INSTR)
		begin
			pc_nxt = pc + 16'd2;
			pc <= pc_nxt;
			fields <= random_fields();				// Held until the next FETCH
			instr_cnt = instr_cnt + 1;
			m_start = 1'b0;
			if (({$random(seed)} % 16) == 0)
			begin
				brkpnt <= pc_nxt;					// Halt in FETCH for a few clocks
				halt_left = 1 + {$random(seed)} % 3;
			end
		end
	endtask

	initial
	begin
		seed = 65;
		cpucycle_rst = 1'b1;
		fields = '0;
		pc = 16'h0100;
		brkpnt = NO_BRK;
		psw_in = 16'h0000;
		psw_wr = 1'b0;
		reset_model();
		repeat (2) @(posedge clock);
		cpucycle_rst <= 1'b0;
		drive_inputs();
		while (!(instr_cnt == NUM_INSTR && m_start && halt_left == 0))
		begin
			@(negedge clock);						// Outputs settled
			check_ctrl(ctrl, m_ctrl);
			check_psw(psw_out, m_psw);
			check_fault(pri_fault, m_fault);
			advance_model(fields, pc == brkpnt, psw_in, psw_wr);
			@(posedge clock);
			drive_inputs();
		end
		@(negedge clock);
		check_ctrl(ctrl, m_ctrl);
		check_psw(psw_out, m_psw);
		check_fault(pri_fault, m_fault);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cex_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module cex_tracker (
	input wire clock,
	input wire cpucycle_rst,
	input wire cu_ctrl_pkg::cpu_cycle_t cycle,
	input wire cu_isa_pkg::instr_fields_t fields,
	input wire cond_true,
	output logic run_ok
);

	logic active;					// Inside a CEX block
	logic result;					// CEX condition outcome
	logic [2:0] true_cnt;			// True group instructions left
	logic [2:0] false_cnt;			// False group instructions left
	logic in_true;					// Current instruction is in the true group

	assign in_true = (true_cnt != 3'd0);
	assign run_ok = !active || (in_true ? result : !result);

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			active <= 1'b0;
			result <= 1'b0;
			true_cnt <= 3'd0;
			false_cnt <= 3'd0;
		end
		else if (cycle == cu_ctrl_pkg::CYC_EXEC1 && fields.op == cu_isa_pkg::OP_CEX)
		begin
			active <= (fields.t != 3'd0) || (fields.f != 3'd0);	// Empty block stays inactive
			result <= cond_true;
			true_cnt <= fields.t;
			false_cnt <= fields.f;
		end
		else if (cycle == cu_ctrl_pkg::CYC_DECODE && active)
		begin
			if (in_true)
			begin
				true_cnt <= true_cnt - 3'd1;
				active <= (true_cnt != 3'd1) || (false_cnt != 3'd0);
			end
			else
			begin
				false_cnt <= false_cnt - 3'd1;
				active <= (false_cnt != 3'd1);		// Last false instruction closes the block
			end
		end
	end

	a_cex_no_underflow: assert property (@(posedge clock) disable iff (cpucycle_rst)
		(cycle == cu_ctrl_pkg::CYC_DECODE && active) |-> (true_cnt != 3'd0 || false_cnt != 3'd0))
		else $error("CEX count decremented below zero");

endmodule

`default_nettype wire

/* verilog/cond_code_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module cond_code_eval (
	input wire cu_isa_pkg::instr_fields_t fields,
	input wire [15:0] psw,
	output logic cond_true
);

	logic [3:0] code;		// Condition selected for this instruction
	logic ge;				// Signed greater or equal, N == V

	assign ge = (psw[cu_isa_pkg::PSW_N] == psw[cu_isa_pkg::PSW_V]);

	always_comb
	begin
		if (fields.op == cu_isa_pkg::OP_CEX)
			code = fields.c;							// CEX carries its own code
		else if (fields.op inside {[cu_isa_pkg::OP_BEQ:cu_isa_pkg::OP_BN]})
			code = fields.op[3:0] - 4'd1;				// BEQ..BN map to EQ..MI
		else if (fields.op inside {[cu_isa_pkg::OP_BGE:cu_isa_pkg::OP_BLT]})
			code = fields.op[3:0] + 4'd4;				// BGE, BLT map to GE, LT
		else
			code = cu_isa_pkg::CC_TR;					// BRA and everything else
	end

	always_comb
	begin
		case (code)
			cu_isa_pkg::CC_EQ: cond_true = psw[cu_isa_pkg::PSW_Z];
			cu_isa_pkg::CC_NE: cond_true = !psw[cu_isa_pkg::PSW_Z];
			cu_isa_pkg::CC_CS: cond_true = psw[cu_isa_pkg::PSW_C];
			cu_isa_pkg::CC_CC: cond_true = !psw[cu_isa_pkg::PSW_C];
			cu_isa_pkg::CC_MI: cond_true = psw[cu_isa_pkg::PSW_N];
			cu_isa_pkg::CC_PL: cond_true = !psw[cu_isa_pkg::PSW_N];
			cu_isa_pkg::CC_VS: cond_true = psw[cu_isa_pkg::PSW_V];
			cu_isa_pkg::CC_VC: cond_true = !psw[cu_isa_pkg::PSW_V];
			cu_isa_pkg::CC_HI: cond_true = psw[cu_isa_pkg::PSW_C] && !psw[cu_isa_pkg::PSW_Z];
			cu_isa_pkg::CC_LS: cond_true = !psw[cu_isa_pkg::PSW_C] || psw[cu_isa_pkg::PSW_Z];
			cu_isa_pkg::CC_GE: cond_true = ge;
			cu_isa_pkg::CC_LT: cond_true = !ge;
			cu_isa_pkg::CC_GT: cond_true = !psw[cu_isa_pkg::PSW_Z] && ge;
			cu_isa_pkg::CC_LE: cond_true = psw[cu_isa_pkg::PSW_Z] || !ge;
			cu_isa_pkg::CC_TR: cond_true = 1'b1;
			cu_isa_pkg::CC_FL: cond_true = 1'b0;
			default: cond_true = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module control_unit (
	input wire clock,
	input wire cpucycle_rst,
	input wire cu_isa_pkg::instr_fields_t fields,	// Held from IR until the instruction ends
	input wire [15:0] pc,
	input wire [15:0] brkpnt,
	input wire [15:0] psw_in,
	input wire psw_wr,
	output cu_ctrl_pkg::ctrl_word_t ctrl,
	output logic [15:0] psw_out,
	output logic pri_fault
);

	cu_ctrl_pkg::cpu_cycle_t cycle;
	logic halted;						// At the breakpoint
	logic last_step;
	logic run_ok;
	logic cond_true;
	logic psw_set;
	logic psw_clr;
	logic pri_req;

	cycle_sequencer u_seq (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .pc(pc), .brkpnt(brkpnt),
		.last_step(last_step), .cycle(cycle), .halted(halted)
	);

	exec_decoder u_dec (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .cycle(cycle), .halted(halted),
		.fields(fields), .run_ok(run_ok), .cond_true(cond_true), .ctrl(ctrl),
		.last_step(last_step), .psw_set(psw_set), .psw_clr(psw_clr), .pri_req(pri_req)
	);

	psw_reg u_psw (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .psw_in(psw_in), .psw_wr(psw_wr),
		.halted(halted), .psw_set(psw_set), .psw_clr(psw_clr), .pri_req(pri_req),
		.fields(fields), .psw(psw_out), .pri_fault(pri_fault)
	);

	cex_tracker u_cex (
		.clock(clock), .cpucycle_rst(cpucycle_rst), .cycle(cycle), .fields(fields),
		.cond_true(cond_true), .run_ok(run_ok)
	);

	cond_code_eval u_cond (
		.fields(fields), .psw(psw_out), .cond_true(cond_true)	// Uses the registered PSW
	);

endmodule

`default_nettype wire

/* verilog/cu_ctrl_pkg.sv */
`default_nettype none

package cu_ctrl_pkg;

	typedef logic [2:0] cpu_cycle_t;			// CPU cycle number, 1 to 6

	localparam cpu_cycle_t CYC_FETCH = 3'd1;	// PC to MAR, memory read
	localparam cpu_cycle_t CYC_PCINC = 3'd2;	// PC plus 2
	localparam cpu_cycle_t CYC_IR = 3'd3;		// Instruction register load
	localparam cpu_cycle_t CYC_DECODE = 3'd4;
	localparam cpu_cycle_t CYC_EXEC1 = 3'd5;
	localparam cpu_cycle_t CYC_EXEC2 = 3'd6;	// Second step of BL and SWAP

	typedef logic [1:0] bus_sel_t;				// Data bus source

	localparam bus_sel_t BUS_MDR = 2'd0;
	localparam bus_sel_t BUS_REG = 2'd1;		// Register file
	localparam bus_sel_t BUS_IR = 2'd2;
	localparam bus_sel_t BUS_UNIT = 2'd2;		// Byte manipulator or sign extender
	localparam bus_sel_t BUS_ALU = 2'd3;

	localparam logic [4:0] REG_LR = 5'd5;		// Link register
	localparam logic [4:0] REG_PC = 5'd7;
	localparam logic [4:0] REG_CONST2 = 5'd10;	// Constant table entry holding 2
	localparam logic [4:0] REG_TEMP = 5'd16;	// Scratch register for SWAP

	localparam logic [5:0] ALU_ADD = 6'd0;
	localparam logic [5:0] ALU_SRA = 6'd24;		// Shifts follow BIS in the ALU table
	localparam logic [2:0] BM_SWPB = 3'd4;		// Byte swap, after the four byte moves
	localparam logic [3:0] SXT_BIT_BYTE = 4'd7;	// SXT extends from bit 7
	localparam logic [3:0] SXT_BIT_BR = 4'd10;	// Branch offset sign bit

	typedef struct packed {
		logic alu_en;				// ALU enable
		logic id_en;				// Instruction decoder enable
		logic sxt_en;				// Sign extender enable
		logic bm_en;				// Byte manipulator enable
		logic mem_rd;				// Memory read from MAR into MDR
		logic mar_from_reg;			// Load MAR from addr_rnum_src
		logic dbus_wr;				// Write the data bus into a register
		logic dbus_wb;				// Byte write when set
		bus_sel_t dbus_src;
		logic [4:0] dbus_rnum_dst;
		logic [4:0] dbus_rnum_src;
		logic [4:0] alu_rnum_dst;	// ALU D-bus operand and result register
		logic [4:0] alu_rnum_src;	// ALU S-bus operand
		logic [4:0] unit_rnum;		// Byte manipulator / sign extender input
		logic [4:0] addr_rnum_src;	// Register driven to the MAR
		logic [5:0] alu_op;
		logic [2:0] bm_op;
		logic [3:0] sxt_bit;		// Bit to extend from
		logic s_bus_sel;			// 1 = sign extender on the ALU S-bus
		logic sxt_sel;				// 1 = sign extender takes the offset field
		logic psw_update;			// ALU writes the flags
	} ctrl_word_t;

endpackage

`default_nettype wire

/* verilog/cu_isa_pkg.sv */
`default_nettype none

package cu_isa_pkg;

	typedef struct packed {
		logic [6:0] op;		// Opcode number from the decoder
		logic [2:0] dst;	// Destination register
		logic [2:0] srccon;	// Source register or constant index
		logic wb;			// 1 = byte, 0 = word
		logic rc;			// 1 = constant table, 0 = register file
		logic [3:0] c;		// CEX condition code
		logic [2:0] t;		// CEX true group length
		logic [2:0] f;		// CEX false group length
		logic [2:0] pr;		// SETPRI requested priority
		logic [4:0] pswb;	// SETCC/CLRCC bit mask (V, SLP, N, Z, C)
	} instr_fields_t;

	localparam logic [6:0] OP_BL = 7'd0;		// Branch with link
	localparam logic [6:0] OP_BEQ = 7'd1;		// First of the EQ..MI branches
	localparam logic [6:0] OP_BN = 7'd5;		// Last of the EQ..MI branches
	localparam logic [6:0] OP_BGE = 7'd6;
	localparam logic [6:0] OP_BLT = 7'd7;
	localparam logic [6:0] OP_BRA = 7'd8;		// Unconditional branch
	localparam logic [6:0] OP_ADD = 7'd9;		// First register ALU op
	localparam logic [6:0] OP_BIS = 7'd20;		// Last register ALU op
	localparam logic [6:0] OP_MOV = 7'd21;
	localparam logic [6:0] OP_SWAP = 7'd22;		// Two steps through TEMP
	localparam logic [6:0] OP_SRA = 7'd23;
	localparam logic [6:0] OP_RRC = 7'd24;
	localparam logic [6:0] OP_SWPB = 7'd25;
	localparam logic [6:0] OP_SXT = 7'd26;
	localparam logic [6:0] OP_SETPRI = 7'd27;
	localparam logic [6:0] OP_SETCC = 7'd29;
	localparam logic [6:0] OP_CLRCC = 7'd30;
	localparam logic [6:0] OP_CEX = 7'd31;		// Conditional execution header
	localparam logic [6:0] OP_MOVL = 7'd34;		// First byte move
	localparam logic [6:0] OP_MOVH = 7'd37;		// Last byte move

	localparam logic [3:0] CC_EQ = 4'd0;
	localparam logic [3:0] CC_NE = 4'd1;
	localparam logic [3:0] CC_CS = 4'd2;
	localparam logic [3:0] CC_CC = 4'd3;
	localparam logic [3:0] CC_MI = 4'd4;
	localparam logic [3:0] CC_PL = 4'd5;
	localparam logic [3:0] CC_VS = 4'd6;
	localparam logic [3:0] CC_VC = 4'd7;
	localparam logic [3:0] CC_HI = 4'd8;
	localparam logic [3:0] CC_LS = 4'd9;
	localparam logic [3:0] CC_GE = 4'd10;
	localparam logic [3:0] CC_LT = 4'd11;
	localparam logic [3:0] CC_GT = 4'd12;
	localparam logic [3:0] CC_LE = 4'd13;
	localparam logic [3:0] CC_TR = 4'd14;		// Always true
	localparam logic [3:0] CC_FL = 4'd15;		// Always false

	localparam int PSW_C = 0;					// Carry
	localparam int PSW_Z = 1;					// Zero
	localparam int PSW_N = 2;					// Negative
	localparam int PSW_SLP = 3;					// Sleep, set while at a breakpoint
	localparam int PSW_V = 4;					// Overflow
	localparam int PSW_PRI_LO = 5;				// Low bit of the 3-bit priority
	localparam logic [15:0] PSW_RESET = 16'h60E0;	// Priority 7, flags clear

endpackage

`default_nettype wire

/* verilog/cycle_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_sequencer (
	input wire clock,
	input wire cpucycle_rst,
	input wire [15:0] pc,
	input wire [15:0] brkpnt,
	input wire last_step,				// Decoder says this cycle ends the instruction
	output cu_ctrl_pkg::cpu_cycle_t cycle,
	output logic halted
);

	assign halted = (pc == brkpnt);		// Breakpoint hit

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			cycle <= cu_ctrl_pkg::CYC_FETCH;
		else if (halted)
			cycle <= cycle;							// Hold until the breakpoint moves
		else if (last_step)
			cycle <= cu_ctrl_pkg::CYC_FETCH;		// Next instruction
		else
			cycle <= cycle + 3'd1;
	end

	a_cycle_range: assert property (@(posedge clock) disable iff (cpucycle_rst)
		(cycle >= cu_ctrl_pkg::CYC_FETCH) && (cycle <= cu_ctrl_pkg::CYC_EXEC2))
		else $error("CPU cycle left the range 1 to 6");

endmodule

`default_nettype wire

/* verilog/exec_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_decoder (
	input wire clock,
	input wire cpucycle_rst,
	input wire cu_ctrl_pkg::cpu_cycle_t cycle,
	input wire halted,
	input wire cu_isa_pkg::instr_fields_t fields,
	input wire run_ok,					// CEX lets this instruction run
	input wire cond_true,				// Branch condition
	output cu_ctrl_pkg::ctrl_word_t ctrl,
	output logic last_step,
	output logic psw_set,
	output logic psw_clr,
	output logic pri_req
);

	cu_ctrl_pkg::ctrl_word_t nxt;		// Word for the current cycle
	logic [4:0] dst_r;					// dst as a register number
	logic [4:0] src_r;					// srccon as a register number

	// PC plus sign-extended offset, shared by branches and BL
	function automatic cu_ctrl_pkg::ctrl_word_t pc_add_word();
		cu_ctrl_pkg::ctrl_word_t w;
		w = '0;
		w.alu_en = 1'b1;
		w.alu_op = cu_ctrl_pkg::ALU_ADD;
		w.alu_rnum_dst = cu_ctrl_pkg::REG_PC;
		w.s_bus_sel = 1'b1;							// Offset on the S-bus
		w.sxt_en = 1'b1;
		w.sxt_sel = 1'b1;
		w.sxt_bit = cu_ctrl_pkg::SXT_BIT_BR;
		return w;
	endfunction

	assign dst_r = {2'b00, fields.dst};
	assign src_r = {2'b00, fields.srccon};

	always_comb
	begin
		nxt = '0;
		nxt.dbus_src = cu_ctrl_pkg::BUS_MDR;		// Bus parks on MDR
		last_step = 1'b0;
		psw_set = 1'b0;
		psw_clr = 1'b0;
		pri_req = 1'b0;
		if (!halted)
		begin
			case (cycle)
				cu_ctrl_pkg::CYC_FETCH:
				begin
					nxt.mar_from_reg = 1'b1;
					nxt.addr_rnum_src = cu_ctrl_pkg::REG_PC;
					nxt.mem_rd = 1'b1;
				end
				cu_ctrl_pkg::CYC_PCINC:
				begin
					nxt.alu_en = 1'b1;
					nxt.alu_op = cu_ctrl_pkg::ALU_ADD;
					nxt.alu_rnum_dst = cu_ctrl_pkg::REG_PC;
					nxt.alu_rnum_src = cu_ctrl_pkg::REG_CONST2;
					nxt.dbus_wr = 1'b1;
					nxt.dbus_src = cu_ctrl_pkg::BUS_ALU;
					nxt.dbus_rnum_dst = cu_ctrl_pkg::REG_PC;
				end
				cu_ctrl_pkg::CYC_IR:
				begin
					nxt.dbus_wr = 1'b1;
					nxt.dbus_src = cu_ctrl_pkg::BUS_IR;
				end
				cu_ctrl_pkg::CYC_DECODE:
				begin
					nxt.id_en = run_ok;
					last_step = !run_ok;						// Skipped by CEX
				end
				cu_ctrl_pkg::CYC_EXEC1:
				begin
					last_step = 1'b1;							// Most instructions end here
					case (fields.op) inside
						[cu_isa_pkg::OP_ADD:cu_isa_pkg::OP_BIS], cu_isa_pkg::OP_SRA,
						cu_isa_pkg::OP_RRC:
						begin
							if (fields.op inside {[cu_isa_pkg::OP_ADD:cu_isa_pkg::OP_BIS]})
								nxt.alu_op = {5'(fields.op - cu_isa_pkg::OP_ADD), fields.wb};
							else
								nxt.alu_op = cu_ctrl_pkg::ALU_SRA +
									{5'(fields.op - cu_isa_pkg::OP_SRA), fields.wb};
							nxt.alu_en = 1'b1;
							nxt.alu_rnum_dst = dst_r;
							nxt.alu_rnum_src = {1'b0, fields.rc, fields.srccon};	// rc selects constants
							nxt.psw_update = 1'b1;
							nxt.dbus_wr = 1'b1;
							nxt.dbus_wb = fields.wb;
							nxt.dbus_src = cu_ctrl_pkg::BUS_ALU;
							nxt.dbus_rnum_dst = dst_r;
						end
						cu_isa_pkg::OP_MOV, cu_isa_pkg::OP_SWAP, cu_isa_pkg::OP_BL:
						begin
							if (fields.op == cu_isa_pkg::OP_BL)
								nxt = pc_add_word();					// Offset add ready for EXEC2
							nxt.dbus_wr = 1'b1;
							nxt.dbus_src = cu_ctrl_pkg::BUS_REG;
							nxt.dbus_wb = (fields.op == cu_isa_pkg::OP_MOV) && fields.wb;
							nxt.dbus_rnum_src = (fields.op == cu_isa_pkg::OP_BL) ?
								cu_ctrl_pkg::REG_PC : src_r;
							case (fields.op)
								cu_isa_pkg::OP_MOV: nxt.dbus_rnum_dst = dst_r;
								cu_isa_pkg::OP_SWAP: nxt.dbus_rnum_dst = cu_ctrl_pkg::REG_TEMP;
								default: nxt.dbus_rnum_dst = cu_ctrl_pkg::REG_LR;	// Return address
							endcase
							last_step = (fields.op == cu_isa_pkg::OP_MOV);
						end
						cu_isa_pkg::OP_SWPB, [cu_isa_pkg::OP_MOVL:cu_isa_pkg::OP_MOVH]:
						begin
							nxt.bm_en = 1'b1;
							nxt.bm_op = (fields.op == cu_isa_pkg::OP_SWPB) ? cu_ctrl_pkg::BM_SWPB :
								3'(fields.op - cu_isa_pkg::OP_MOVL);
							nxt.unit_rnum = dst_r;
							nxt.dbus_wr = 1'b1;
							nxt.dbus_src = cu_ctrl_pkg::BUS_UNIT;
							nxt.dbus_rnum_dst = dst_r;
						end
						cu_isa_pkg::OP_SXT:
						begin
							nxt.sxt_en = 1'b1;
							nxt.sxt_bit = cu_ctrl_pkg::SXT_BIT_BYTE;
							nxt.sxt_sel = 1'b0;							// Register input
							nxt.unit_rnum = dst_r;
							nxt.dbus_wr = 1'b1;
							nxt.dbus_src = cu_ctrl_pkg::BUS_UNIT;
							nxt.dbus_rnum_dst = dst_r;
						end
						[cu_isa_pkg::OP_BEQ:cu_isa_pkg::OP_BRA]:
						begin
							if (cond_true)
							begin
								nxt = pc_add_word();
								nxt.dbus_wr = 1'b1;
								nxt.dbus_src = cu_ctrl_pkg::BUS_ALU;
								nxt.dbus_rnum_dst = cu_ctrl_pkg::REG_PC;
							end
						end
						cu_isa_pkg::OP_SETCC: psw_set = 1'b1;
						cu_isa_pkg::OP_CLRCC: psw_clr = 1'b1;
						cu_isa_pkg::OP_SETPRI: pri_req = 1'b1;
						default: nxt.id_en = 1'b0;						// CEX and unused codes idle
					endcase
				end
				cu_ctrl_pkg::CYC_EXEC2:
				begin
					last_step = 1'b1;
					if (fields.op == cu_isa_pkg::OP_BL)
					begin
						nxt = pc_add_word();						// Jump to the target
						nxt.dbus_wr = 1'b1;
						nxt.dbus_src = cu_ctrl_pkg::BUS_ALU;
						nxt.dbus_rnum_dst = cu_ctrl_pkg::REG_PC;
					end
					else if (fields.op == cu_isa_pkg::OP_SWAP)
					begin
						nxt.dbus_wr = 1'b1;
						nxt.dbus_src = cu_ctrl_pkg::BUS_REG;
						nxt.dbus_rnum_src = cu_ctrl_pkg::REG_TEMP;
						nxt.dbus_rnum_dst = dst_r;
					end
				end
				default: last_step = 1'b1;							// Recover to FETCH
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
			ctrl <= '0;										// Idle word
		else
			ctrl <= nxt;
	end

endmodule

`default_nettype wire

/* verilog/psw_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module psw_reg (
	input wire clock,
	input wire cpucycle_rst,
	input wire [15:0] psw_in,			// Flags from the datapath
	input wire psw_wr,
	input wire halted,
	input wire psw_set,					// SETCC strobe
	input wire psw_clr,					// CLRCC strobe
	input wire pri_req,					// SETPRI strobe
	input wire cu_isa_pkg::instr_fields_t fields,
	output logic [15:0] psw,
	output logic pri_fault
);

	logic [15:0] psw_next;
	logic [2:0] cur_pri;				// Running priority
	logic lowers;						// Requested priority is below the current one

	assign cur_pri = psw[cu_isa_pkg::PSW_PRI_LO +: 3];
	assign lowers = (fields.pr < cur_pri);

	always_comb
	begin
		psw_next = psw_wr ? psw_in : psw;					// Datapath load first
		if (psw_set)
			psw_next[4:0] = psw[4:0] | fields.pswb;			// Instruction wins on the flags
		else if (psw_clr)
			psw_next[4:0] = psw[4:0] & ~fields.pswb;
		if (pri_req && lowers)
			psw_next[cu_isa_pkg::PSW_PRI_LO +: 3] = fields.pr;
		psw_next[cu_isa_pkg::PSW_SLP] = halted;				// Sleep mirrors the breakpoint hold
	end

	always_ff @(posedge clock)
	begin
		if (cpucycle_rst)
		begin
			psw <= cu_isa_pkg::PSW_RESET;
			pri_fault <= 1'b0;
		end
		else
		begin
			psw <= psw_next;
			pri_fault <= pri_req && !lowers;				// Raising or equal priority faults
		end
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verification
verilog/cu_isa_pkg.sv
verilog/cu_ctrl_pkg.sv
verilog/cond_code_eval.sv
verilog/psw_reg.sv
verilog/cex_tracker.sv
verilog/cycle_sequencer.sv
verilog/exec_decoder.sv
verilog/control_unit.sv
verification/tb_control_unit.sv
